// ==== project.f ====
source/xyolo_ctrl_pkg.sv
source/conf_regs.sv
source/stage_addr_calc.sv
source/conf_shadow.sv
source/acc_sequencer.sv
source/xyolo_ctrl_top.sv
verif/xyolo_ctrl_sva.sv
verif/xyolo_ctrl_checker.sv
verif/tb_xyolo_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f project.f --top-module tb_xyolo_ctrl -o sim_xyolo_ctrl
status=$?
if [ $status -ne 0 ]; then
   echo "compile failed with status $status"
   exit 1
fi

out=$(./obj_dir/sim_xyolo_ctrl 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "test passed" <<< "$out"; then
   exit 0
fi
exit 1

// ==== verif/tb_xyolo_ctrl.sv ====
module tb_xyolo_ctrl;
   timeunit 1ns;
   timeprecision 100ps;
   import xyolo_ctrl_pkg::*;

   localparam int N_STAGES = 4;
   localparam int READ_LAT = 2;
   localparam int N_ROWS   = 6;
   localparam int PERIOD   = 4;

   // layer rows, flags are {bypass, maxpool, leaky, bias}
   io_addr_t   t_ext   [N_ROWS] = '{32'h1000_0000, 32'hFFFF_FF00, 32'h0000_4000,
                                    32'h2345_6789, 32'h8000_0000, 32'h0000_0000};
   offset_t    t_off   [N_ROWS] = '{16'h0100, 16'h0080, 16'hFFFF, 16'h1234, 16'h0001, 16'h4000};
   axi_len_t   t_len   [N_ROWS] = '{8'd16, 8'd0, 8'd255, 8'd1, 8'd8, 8'd4};
   mem_addr_t  t_iter  [N_ROWS] = '{10'd3, 10'd2, 10'd0, 10'd4, 10'd1, 10'd5};
   period_t    t_per   [N_ROWS] = '{6'd4, 6'd3, 6'd5, 6'd2, 6'd1, 6'd3};
   shift_t     t_shift [N_ROWS] = '{5'd5, 5'd2, 5'd7, 5'd31, 5'd0, 5'd9};
   logic [3:0] t_flags [N_ROWS] = '{4'b0101, 4'b0010, 4'b0000, 4'b1000, 4'b0111, 4'b1001};

   logic       clk;
   logic       rst;
   logic       valid;
   logic       wstrb;
   conf_addr_e addr;
   conf_word_t wdata;
   logic       run;

   io_addr_t [N_STAGES-1:0] stage_ext_addr;
   logic      buffer_sel;
   axi_len_t  dma_len;
   shift_t    shift;
   logic      bias;
   logic      leaky;
   logic      maxpool;
   mem_addr_t acc_addr;
   logic      acc_valid;
   logic      ld_acc;
   logic      ld_res;
   logic      ld_mp;
   logic      done;

   // row of the layer that is running
   io_addr_t   cur_ext;
   offset_t    cur_off;
   axi_len_t   cur_len;
   mem_addr_t  cur_iter;
   period_t    cur_per;
   shift_t     cur_shift;
   logic [3:0] cur_flags;

   int seed = 70657;
   int value_errors;
   int event_errors;
   int layers;
   int tb_errors;

   xyolo_ctrl_top #(
      .N_STAGES (N_STAGES),
      .READ_LAT (READ_LAT)
   ) UUT (
      .clk (clk), .rst (rst), .valid (valid), .wstrb (wstrb), .addr (addr),
      .wdata (wdata), .run (run), .stage_ext_addr (stage_ext_addr),
      .buffer_sel (buffer_sel), .dma_len (dma_len), .shift (shift), .bias (bias),
      .leaky (leaky), .maxpool (maxpool), .acc_addr (acc_addr), .acc_valid (acc_valid),
      .ld_acc (ld_acc), .ld_res (ld_res), .ld_mp (ld_mp), .done (done)
   );

   xyolo_ctrl_checker #(
      .N_STAGES (N_STAGES),
      .READ_LAT (READ_LAT)
   ) chk (
      .clk (clk), .rst (rst), .run (run), .row_ext_addr (cur_ext), .row_offset (cur_off),
      .row_len (cur_len), .row_iter (cur_iter), .row_per (cur_per), .row_shift (cur_shift),
      .row_flags (cur_flags), .stage_ext_addr (stage_ext_addr), .buffer_sel (buffer_sel),
      .dma_len (dma_len), .shift (shift), .bias (bias), .leaky (leaky), .maxpool (maxpool),
      .acc_addr (acc_addr), .acc_valid (acc_valid), .ld_acc (ld_acc), .ld_res (ld_res),
      .ld_mp (ld_mp), .done (done), .value_errors (value_errors),
      .event_errors (event_errors), .layers (layers)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic write_reg(input conf_addr_e a, input logic [31:0] v);
      valid       = 1'b1;
      wstrb       = 1'b1;
      addr        = a;
      wdata.value = v;
      next_cycle();
      valid = 1'b0;
      wstrb = 1'b0;
   endtask

   task automatic write_row(input int r);
      logic [31:0] word;
      write_reg(CONF_EXT_ADDR, t_ext[r]);
      write_reg(CONF_OFFSET, 32'(t_off[r]));
      write_reg(CONF_LEN, 32'(t_len[r]));
      write_reg(CONF_ITER, 32'(t_iter[r]));
      write_reg(CONF_PER, 32'(t_per[r]));
      write_reg(CONF_SHIFT, 32'(t_shift[r]));
      // reserved flag bits carry noise
      word      = $random(seed);
      word[3:0] = t_flags[r];
      write_reg(CONF_FLAGS, word);
   endtask

   task automatic pulse_run(input int r);
      cur_ext   = t_ext[r];
      cur_off   = t_off[r];
      cur_len   = t_len[r];
      cur_iter  = t_iter[r];
      cur_per   = t_per[r];
      cur_shift = t_shift[r];
      cur_flags = t_flags[r];
      run       = 1'b1;
      next_cycle();
      run = 1'b0;
   endtask

   task automatic wait_done();
      while (!done) begin
         next_cycle();
      end
   endtask

   // watchdog sized from the table
   initial begin
      int limit;
      limit = 8;
      for (int r = 0; r < N_ROWS; r++) begin
         limit += int'(t_iter[r]) * int'(t_per[r]) + 20;
      end
      #(limit * PERIOD);
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("test failed");
      $finish;
   end

   initial begin
      rst         = 1'b1;
      valid       = 1'b0;
      wstrb       = 1'b0;
      addr        = CONF_EXT_ADDR;
      wdata.value = '0;
      run         = 1'b0;
      cur_ext     = '0;
      cur_off     = '0;
      cur_len     = '0;
      cur_iter    = '0;
      cur_per     = '0;
      cur_shift   = '0;
      cur_flags   = '0;
      tb_errors   = 0;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      next_cycle();
      write_row(0);
      for (int r = 0; r < N_ROWS; r++) begin
         repeat (MUL_LAT + 1) next_cycle();
         pulse_run(r);
         // next row lands in the live registers while this layer runs
         if (r + 1 < N_ROWS) begin
            write_row(r + 1);
         end else begin
            repeat (2) next_cycle();
         end
         wait_done();
      end
      repeat (3) next_cycle();
      if (layers != N_ROWS) begin
         tb_errors++;
         $display("checker saw %0d layers instead of %0d", layers, N_ROWS);
      end
      $display("errors: value %0d, event %0d, testbench %0d",
               value_errors, event_errors, tb_errors);
      if (value_errors + event_errors + tb_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// ==== verif/xyolo_ctrl_checker.sv ====
module xyolo_ctrl_checker #(
   parameter int N_STAGES = 4,
   parameter int READ_LAT = 2
) (
   input  logic                                    clk,
   input  logic                                    rst,
   input  logic                                    run,
   input  xyolo_ctrl_pkg::io_addr_t                row_ext_addr,
   input  xyolo_ctrl_pkg::offset_t                 row_offset,
   input  xyolo_ctrl_pkg::axi_len_t                row_len,
   input  xyolo_ctrl_pkg::mem_addr_t               row_iter,
   input  xyolo_ctrl_pkg::period_t                 row_per,
   input  xyolo_ctrl_pkg::shift_t                  row_shift,
   input  logic [3:0]                              row_flags,
   input  xyolo_ctrl_pkg::io_addr_t [N_STAGES-1:0] stage_ext_addr,
   input  logic                                    buffer_sel,
   input  xyolo_ctrl_pkg::axi_len_t                dma_len,
   input  xyolo_ctrl_pkg::shift_t                  shift,
   input  logic                                    bias,
   input  logic                                    leaky,
   input  logic                                    maxpool,
   input  xyolo_ctrl_pkg::mem_addr_t               acc_addr,
   input  logic                                    acc_valid,
   input  logic                                    ld_acc,
   input  logic                                    ld_res,
   input  logic                                    ld_mp,
   input  logic                                    done,
   output int                                      value_errors,
   output int                                      event_errors,
   output int                                      layers
);
   timeunit 1ns;
   timeprecision 100ps;
   import xyolo_ctrl_pkg::*;

   // expected row, latched when run is seen
   io_addr_t   e_ext;
   offset_t    e_off;
   axi_len_t   e_len;
   shift_t     e_shift;
   logic [3:0] e_flags;
   int         e_iter;
   int         e_per;
   int         n_acc;
   int         cyc;
   int         last_cyc;
   int         mp_exp;
   int         res_seen;
   int         res_want;
   logic       active;
   logic       buf_exp;

   // cycles are counted from the run edge
   function automatic logic valid_at(int c);
      return (n_acc > 0) && (c >= READ_LAT + 2) && (c <= READ_LAT + 1 + n_acc);
   endfunction

   function automatic logic res_at(int c);
      if (e_flags[3]) begin
         return valid_at(c);
      end
      return valid_at(c - 2) && (((c - 2 - (READ_LAT + 2)) % e_per) == e_per - 1);
   endfunction

   task automatic compare(input string what, input logic [63:0] got, input logic [63:0] want);
      if (got !== want) begin
         value_errors++;
         $display("[ERROR] %0t ns: layer %0d %s is %0h, expected %0h",
                  $time, layers, what, got, want);
      end
   endtask

   task automatic start_layer();
      if (active) begin
         event_errors++;
         $display("run pulsed at %0t ns while layer %0d was still running", $time, layers);
      end
      e_ext    = row_ext_addr;
      e_off    = row_offset;
      e_len    = row_len;
      e_shift  = row_shift;
      e_flags  = row_flags;
      e_iter   = int'(row_iter);
      e_per    = int'(row_per);
      buf_exp  = buf_exp ^ (row_len != 0);
      n_acc    = (e_iter == 0 || e_per == 0) ? 0 : e_iter * e_per;
      if (n_acc == 0) begin
         last_cyc = 2;
      end else begin
         last_cyc = e_flags[3] ? READ_LAT + n_acc + 2 : READ_LAT + n_acc + 4;
      end
      res_want = (n_acc == 0) ? 0 : (e_flags[3] ? n_acc : e_iter);
      mp_exp   = e_flags[3] ? 0 : 3;
      res_seen = 0;
      // run edge is still ahead
      cyc      = -1;
      active   = 1'b1;
      layers++;
   endtask

   // between layers the sequencer rests with done high
   task automatic check_idle();
      compare("done", done, 1'b1);
      compare("acc_valid", acc_valid, 1'b0);
      compare("ld_acc", ld_acc, 1'b0);
      compare("ld_res", ld_res, 1'b0);
      if (layers == 0) begin
         compare("ld_mp", ld_mp, 1'b0);
      end
   endtask

   task automatic check_cycle();
      io_addr_t want_addr;
      logic     want_valid;
      logic     want_res;
      for (int i = 0; i < N_STAGES; i++) begin
         want_addr = e_ext + io_addr_t'(e_off) * io_addr_t'(i);
         compare($sformatf("stage_ext_addr[%0d]", i), stage_ext_addr[i], want_addr);
      end
      compare("dma_len", dma_len, e_len);
      compare("shift", shift, e_shift);
      compare("bias", bias, e_flags[0]);
      compare("leaky", leaky, e_flags[1]);
      compare("maxpool", maxpool, e_flags[2]);
      compare("buffer_sel", buffer_sel, buf_exp);
      if (cyc == last_cyc && !done) begin
         event_errors++;
         $display("done did not return high at the end of layer %0d", layers);
      end else begin
         compare("done", done, cyc >= last_cyc);
      end
      want_valid = valid_at(cyc);
      compare("acc_valid", acc_valid, want_valid);
      if (want_valid) begin
         compare("acc_addr", acc_addr, (cyc - (READ_LAT + 2)) % e_per);
      end
      compare("ld_acc", ld_acc, want_valid && ((cyc - (READ_LAT + 2)) % e_per == 0));
      want_res = res_at(cyc);
      compare("ld_res", ld_res, want_res);
      if (ld_res) begin
         res_seen++;
      end
      compare("ld_mp", ld_mp, mp_exp != 0);
      if (want_res) begin
         mp_exp = (mp_exp + 1) % 4;
      end
      if (cyc == last_cyc) begin
         if (res_seen < res_want) begin
            event_errors++;
            $display("layer %0d is missing ld_res pulses, saw %0d of %0d",
                     layers, res_seen, res_want);
         end
         active = 1'b0;
      end
   endtask

   // outputs are stable mid cycle
   always @(negedge clk) begin
      if (rst) begin
         active  = 1'b0;
         buf_exp = 1'b0;
      end else begin
         if (active) begin
            cyc++;
         end
         // the run_d cycle still shows the idle state
         if (active && cyc > 0) begin
            check_cycle();
         end else begin
            check_idle();
         end
         if (run) begin
            start_layer();
         end
      end
   end

endmodule

// ==== verif/xyolo_ctrl_sva.sv ====
module xyolo_ctrl_sva (
   input logic clk,
   input logic rst,
   input logic run_d,
   input logic acc_valid,
   input logic ld_acc,
   input logic done
);
   timeunit 1ns;
   timeprecision 100ps;

   // a layer always opens on address 0
   ld_acc_at_start: assert property (
      @(posedge clk) disable iff (rst) $rose(acc_valid) |-> ld_acc
   ) else $error("first acc_valid cycle of a layer without ld_acc");

   done_excludes_valid: assert property (
      @(posedge clk) disable iff (rst) !(done && acc_valid)
   ) else $error("done and acc_valid high in the same cycle");

   // a new layer may only start once the last one is finished
   run_only_when_done: assert property (
      @(posedge clk) disable iff (rst) run_d |-> done
   ) else $error("run arrived while the sequencer was busy");

endmodule

bind acc_sequencer xyolo_ctrl_sva u_sva (
   .clk       (clk),
   .rst       (rst),
   .run_d     (run_d),
   .acc_valid (acc_valid),
   .ld_acc    (ld_acc),
   .done      (done)
);

// ==== source/xyolo_ctrl_top.sv ====
module xyolo_ctrl_top #(
   parameter int N_STAGES = 4,
   parameter int READ_LAT = 2
) (
   input  logic                                    clk,
   input  logic                                    rst,
   input  logic                                    valid,
   input  logic                                    wstrb,
   input  xyolo_ctrl_pkg::conf_addr_e              addr,
   input  xyolo_ctrl_pkg::conf_word_t              wdata,
   input  logic                                    run,
   output xyolo_ctrl_pkg::io_addr_t [N_STAGES-1:0] stage_ext_addr,
   output logic                                    buffer_sel,
   output xyolo_ctrl_pkg::axi_len_t                dma_len,
   output xyolo_ctrl_pkg::shift_t                  shift,
   output logic                                    bias,
   output logic                                    leaky,
   output logic                                    maxpool,
   output xyolo_ctrl_pkg::mem_addr_t               acc_addr,
   output logic                                    acc_valid,
   output logic                                    ld_acc,
   output logic                                    ld_res,
   output logic                                    ld_mp,
   output logic                                    done
);
   import xyolo_ctrl_pkg::*;

   // live configuration
   io_addr_t     ext_addr;
   offset_t      offset;
   axi_len_t     len;
   mem_addr_t    iter;
   period_t      per;
   shift_t       live_shift;
   layer_flags_t flags;

   io_addr_t [N_STAGES-1:0] stage_addr;

   // captured for the running layer
   mem_addr_t iter_s;
   period_t   per_s;
   logic      bypass;
   logic      run_d;

   conf_regs u_conf_regs (
      .clk      (clk),
      .rst      (rst),
      .valid    (valid),
      .wstrb    (wstrb),
      .addr     (addr),
      .wdata    (wdata),
      .ext_addr (ext_addr),
      .offset   (offset),
      .len      (len),
      .iter     (iter),
      .per      (per),
      .shift    (live_shift),
      .flags    (flags)
   );

   stage_addr_calc #(
      .N_STAGES (N_STAGES)
   ) u_stage_addr_calc (
      .clk        (clk),
      .rst        (rst),
      .ext_addr   (ext_addr),
      .offset     (offset),
      .stage_addr (stage_addr)
   );

   conf_shadow #(
      .N_STAGES (N_STAGES)
   ) u_conf_shadow (
      .clk            (clk),
      .rst            (rst),
      .run            (run),
      .stage_addr     (stage_addr),
      .len            (len),
      .iter           (iter),
      .per            (per),
      .shift          (live_shift),
      .flags          (flags),
      .stage_ext_addr (stage_ext_addr),
      .buffer_sel     (buffer_sel),
      .dma_len        (dma_len),
      .iter_s         (iter_s),
      .per_s          (per_s),
      .shift_s        (shift),
      .bias           (bias),
      .leaky          (leaky),
      .maxpool        (maxpool),
      .bypass         (bypass),
      .run_d          (run_d)
   );

   acc_sequencer #(
      .READ_LAT (READ_LAT)
   ) u_acc_sequencer (
      .clk       (clk),
      .rst       (rst),
      .run_d     (run_d),
      .iter_s    (iter_s),
      .per_s     (per_s),
      .bypass    (bypass),
      .acc_addr  (acc_addr),
      .acc_valid (acc_valid),
      .ld_acc    (ld_acc),
      .ld_res    (ld_res),
      .ld_mp     (ld_mp),
      .done      (done)
   );

endmodule

// ==== source/acc_sequencer.sv ====
module acc_sequencer #(
   parameter int READ_LAT = 2
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      run_d,
   input  xyolo_ctrl_pkg::mem_addr_t iter_s,
   input  xyolo_ctrl_pkg::period_t   per_s,
   input  logic                      bypass,
   output xyolo_ctrl_pkg::mem_addr_t acc_addr,
   output logic                      acc_valid,
   output logic                      ld_acc,
   output logic                      ld_res,
   output logic                      ld_mp,
   output logic                      done
);
   import xyolo_ctrl_pkg::*;

   localparam int LAT_W = (READ_LAT > 0) ? $clog2(READ_LAT + 1) : 1;

   logic             waiting;
   logic [LAT_W-1:0] lat_cnt;
   mem_addr_t        iter_cnt;
   mem_addr_t        per_last;
   logic             empty;
   logic             period_end;
   logic             last_end;
   logic             done_set;
   logic [1:0]       res_dly;
   logic [1:0]       last_dly;
   logic [1:0]       mp_cnt;

   assign empty      = (iter_s == '0) || (per_s == '0);
   assign per_last   = mem_addr_t'(per_s) - mem_addr_t'(1);
   assign period_end = acc_valid && (acc_addr == per_last);
   assign last_end   = period_end && (iter_cnt == iter_s - mem_addr_t'(1));

   // read latency wait, then period and iteration counters
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         waiting   <= 1'b0;
         lat_cnt   <= '0;
         acc_valid <= 1'b0;
         acc_addr  <= '0;
         iter_cnt  <= '0;
      end else if (run_d) begin
         waiting   <= 1'b1;
         lat_cnt   <= LAT_W'(READ_LAT);
         acc_valid <= 1'b0;
      end else if (waiting) begin
         if (empty) begin
            waiting <= 1'b0;
         end else if (lat_cnt == '0) begin
            waiting   <= 1'b0;
            acc_valid <= 1'b1;
            acc_addr  <= '0;
            iter_cnt  <= '0;
         end else begin
            lat_cnt <= lat_cnt - 1'b1;
         end
      end else if (acc_valid) begin
         if (period_end) begin
            acc_addr  <= '0;
            iter_cnt  <= iter_cnt + mem_addr_t'(1);
            acc_valid <= !last_end;
         end else begin
            acc_addr <= acc_addr + mem_addr_t'(1);
         end
      end
   end

   // result strobe trails the period end by two cycles
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         res_dly  <= '0;
         last_dly <= '0;
         mp_cnt   <= '0;
      end else begin
         res_dly  <= {res_dly[0], period_end};
         last_dly <= {last_dly[0], last_end};
         if (run_d) begin
            mp_cnt <= bypass ? 2'd0 : 2'd3;
         end else if (ld_res) begin
            mp_cnt <= mp_cnt + 2'd1;
         end
      end
   end

   assign done_set = bypass ? last_end : last_dly[1];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done <= 1'b1;
      end else if (run_d) begin
         done <= 1'b0;
      end else if ((waiting && empty) || done_set) begin
         done <= 1'b1;
      end
   end

   assign ld_acc = acc_valid && (acc_addr == '0);
   assign ld_res = bypass ? acc_valid : res_dly[1];
   assign ld_mp  = (mp_cnt != 2'd0);

endmodule

// ==== source/conf_shadow.sv ====
module conf_shadow #(
   parameter int N_STAGES = 4
) (
   input  logic                                    clk,
   input  logic                                    rst,
   input  logic                                    run,
   input  xyolo_ctrl_pkg::io_addr_t [N_STAGES-1:0] stage_addr,
   input  xyolo_ctrl_pkg::axi_len_t                len,
   input  xyolo_ctrl_pkg::mem_addr_t               iter,
   input  xyolo_ctrl_pkg::period_t                 per,
   input  xyolo_ctrl_pkg::shift_t                  shift,
   input  xyolo_ctrl_pkg::layer_flags_t            flags,
   output xyolo_ctrl_pkg::io_addr_t [N_STAGES-1:0] stage_ext_addr,
   output logic                                    buffer_sel,
   output xyolo_ctrl_pkg::axi_len_t                dma_len,
   output xyolo_ctrl_pkg::mem_addr_t               iter_s,
   output xyolo_ctrl_pkg::period_t                 per_s,
   output xyolo_ctrl_pkg::shift_t                  shift_s,
   output logic                                    bias,
   output logic                                    leaky,
   output logic                                    maxpool,
   output logic                                    bypass,
   output logic                                    run_d
);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         run_d          <= 1'b0;
         stage_ext_addr <= '0;
         buffer_sel     <= 1'b0;
         dma_len        <= '0;
         iter_s         <= '0;
         per_s          <= '0;
         shift_s        <= '0;
         bias           <= 1'b0;
         leaky          <= 1'b0;
         maxpool        <= 1'b0;
         bypass         <= 1'b0;
      end else begin
         run_d <= run;
         // live regs stay free for the next layer once captured
         if (run) begin
            stage_ext_addr <= stage_addr;
            dma_len        <= len;
            iter_s         <= iter;
            per_s          <= per;
            shift_s        <= shift;
            bias           <= flags.bias;
            leaky          <= flags.leaky;
            maxpool        <= flags.maxpool;
            bypass         <= flags.bypass;
            // ping-pong only when the layer moves external data
            buffer_sel     <= buffer_sel ^ (len != '0);
         end
      end
   end

endmodule

// ==== source/stage_addr_calc.sv ====
module stage_addr_calc #(
   parameter int N_STAGES = 4
) (
   input  logic                                    clk,
   input  logic                                    rst,
   input  xyolo_ctrl_pkg::io_addr_t                ext_addr,
   input  xyolo_ctrl_pkg::offset_t                 offset,
   output xyolo_ctrl_pkg::io_addr_t [N_STAGES-1:0] stage_addr
);
   import xyolo_ctrl_pkg::*;

   // input regs and product take two of the MUL_LAT cycles
   localparam int SUM_DEPTH = MUL_LAT - 2;

   io_addr_t base_q;
   io_addr_t base_d;
   offset_t  off_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         base_q <= '0;
         base_d <= '0;
         off_q  <= '0;
      end else begin
         base_q <= ext_addr;
         off_q  <= offset;
         base_d <= base_q;
      end
   end

   // stage 0 sits at the base
   assign stage_addr[0] = ext_addr;

   for (genvar i = 1; i < N_STAGES; i++) begin : g_stage
      io_addr_t prod;
      io_addr_t sum_pipe [SUM_DEPTH];

      always_ff @(posedge clk or posedge rst) begin
         if (rst) begin
            prod <= '0;
            for (int j = 0; j < SUM_DEPTH; j++) begin
               sum_pipe[j] <= '0;
            end
         end else begin
            prod        <= io_addr_t'(off_q) * io_addr_t'(i);
            sum_pipe[0] <= prod + base_d;
            for (int j = 1; j < SUM_DEPTH; j++) begin
               sum_pipe[j] <= sum_pipe[j-1];
            end
         end
      end

      assign stage_addr[i] = sum_pipe[SUM_DEPTH-1];
   end

endmodule

// ==== source/conf_regs.sv ====
module conf_regs (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       valid,
   input  logic                       wstrb,
   input  xyolo_ctrl_pkg::conf_addr_e addr,
   input  xyolo_ctrl_pkg::conf_word_t wdata,
   output xyolo_ctrl_pkg::io_addr_t     ext_addr,
   output xyolo_ctrl_pkg::offset_t      offset,
   output xyolo_ctrl_pkg::axi_len_t     len,
   output xyolo_ctrl_pkg::mem_addr_t    iter,
   output xyolo_ctrl_pkg::period_t      per,
   output xyolo_ctrl_pkg::shift_t       shift,
   output xyolo_ctrl_pkg::layer_flags_t flags
);
   import xyolo_ctrl_pkg::*;

   logic wr;
   logic ext_addr_en;
   logic offset_en;
   logic len_en;
   logic iter_en;
   logic per_en;
   logic shift_en;
   logic flags_en;

   assign wr = valid && wstrb;

   // one enable per register
   always_comb begin
      ext_addr_en = 1'b0;
      offset_en   = 1'b0;
      len_en      = 1'b0;
      iter_en     = 1'b0;
      per_en      = 1'b0;
      shift_en    = 1'b0;
      flags_en    = 1'b0;
      if (wr) begin
         case (addr)
            CONF_EXT_ADDR: ext_addr_en = 1'b1;
            CONF_OFFSET:   offset_en   = 1'b1;
            CONF_LEN:      len_en      = 1'b1;
            CONF_ITER:     iter_en     = 1'b1;
            CONF_PER:      per_en      = 1'b1;
            CONF_SHIFT:    shift_en    = 1'b1;
            CONF_FLAGS:    flags_en    = 1'b1;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ext_addr <= '0;
         offset   <= '0;
         len      <= '0;
         iter     <= '0;
         per      <= '0;
         shift    <= '0;
         flags    <= '0;
      end else begin
         if (ext_addr_en) begin
            ext_addr <= wdata.value;
         end
         if (offset_en) begin
            offset <= wdata.value[OFFSET_W-1:0];
         end
         if (len_en) begin
            len <= wdata.value[AXI_LEN_W-1:0];
         end
         if (iter_en) begin
            iter <= wdata.value[MEM_ADDR_W-1:0];
         end
         if (per_en) begin
            per <= wdata.value[PERIOD_W-1:0];
         end
         if (shift_en) begin
            shift <= wdata.value[SHIFT_W-1:0];
         end
         // same word, read as option bits
         if (flags_en) begin
            flags <= wdata.flags;
         end
      end
   end

endmodule

// ==== source/xyolo_ctrl_pkg.sv ====
package xyolo_ctrl_pkg;

   // datapath widths
   parameter int IO_ADDR_W   = 32;
   parameter int OFFSET_W    = IO_ADDR_W / 2;
   parameter int MEM_ADDR_W  = 10;
   parameter int PERIOD_W    = 6;
   parameter int SHIFT_W     = 5;
   parameter int AXI_LEN_W   = 8;
   parameter int CONF_ADDR_W = 4;

   // stage address multiply-add pipeline depth
   parameter int MUL_LAT = 3;

   typedef logic [IO_ADDR_W-1:0]  io_addr_t;
   typedef logic [OFFSET_W-1:0]   offset_t;
   typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
   typedef logic [PERIOD_W-1:0]   period_t;
   typedef logic [SHIFT_W-1:0]    shift_t;
   typedef logic [AXI_LEN_W-1:0]  axi_len_t;

   // cpu register map
   typedef enum logic [CONF_ADDR_W-1:0] {
      CONF_EXT_ADDR = 0,
      CONF_OFFSET   = 1,
      CONF_LEN      = 2,
      CONF_ITER     = 3,
      CONF_PER      = 4,
      CONF_SHIFT    = 5,
      CONF_FLAGS    = 6
   } conf_addr_e;

   // layer option bits, bias in bit 0
   typedef struct packed {
      logic [IO_ADDR_W-5:0] reserved;
      logic                 bypass;
      logic                 maxpool;
      logic                 leaky;
      logic                 bias;
   } layer_flags_t;

   // write word, number or flag bits depending on target register
   typedef union packed {
      io_addr_t     value;
      layer_flags_t flags;
   } conf_word_t;

endpackage
